//--- hdl/adder_tree.sv
module adder_tree
        import fir_types_pkg::*, fir_coeff_pkg::*;
(
        input  logic         clk,
        input  logic         rst,
        input  product_vec_t products,
        output acc_t         result
);

        localparam int LEVELS = 6;                           // 50 25 13 7 4 2 1
        localparam int TOP_W  = $bits(product_t) + LEVELS;

        // Element count after a given number of pairwise levels
        function automatic int level_count(int lvl);
                int n;
                n = HALF_TAPS;
                for (int i = 0; i < lvl; i++) begin
                        n = (n + 1) / 2;
                end
                return n;
        endfunction

        logic signed [TOP_W-1:0] final_sum;

        for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
                localparam int CNT = level_count(l);
                localparam int W   = $bits(product_t) + l;      // One bit of growth per level

                logic signed [W-1:0] sum [CNT];

                if (l == 0) begin : g_in
                        always_comb begin
                                for (int i = 0; i < CNT; i++) begin
                                        sum[i] = $signed(products[i]);
                                end
                        end
                end else begin : g_add
                        localparam int PREV = level_count(l - 1);

                        always_ff @(posedge clk) begin
                                if (rst) begin
                                        for (int i = 0; i < CNT; i++) begin
                                                sum[i] <= '0;
                                        end
                                end else begin
                                        for (int i = 0; i < PREV / 2; i++) begin
                                                sum[i] <= g_lvl[l-1].sum[2*i] +
                                                          g_lvl[l-1].sum[2*i+1];
                                        end
                                        if (PREV % 2 == 1) begin
                                                sum[CNT-1] <= g_lvl[l-1].sum[PREV-1];  // Odd one out
                                        end
                                end
                        end
                end
        end

        assign final_sum = g_lvl[LEVELS].sum[0];
        assign result    = acc_t'(final_sum);   // Drop the unused growth bits

        // Bits above the output must only repeat the sign
        a_no_overflow : assert property (
                @(posedge clk) disable iff (rst)
                (final_sum[TOP_W-1:ACC_W-1] == '0) || (final_sum[TOP_W-1:ACC_W-1] == '1)
        ) else $error("adder tree sum exceeds output width");

endmodule

//--- hdl/fir_coeff_pkg.sv
package fir_coeff_pkg;

        localparam int TAPS         = 100;
        localparam int HALF_TAPS    = TAPS / 2;   // Folded pairs
        localparam int PIPE_LATENCY = 9;          // Sample in to result out

        typedef logic signed [15:0] coeff_t;

        // Taps 0 to 49 of the symmetric response; tap k above 49 uses entry 99-k
        localparam coeff_t COEFFS [HALF_TAPS] = '{
                -16'sd5,
                -16'sd14,
                -16'sd18,
                -16'sd16,
                -16'sd6,
                16'sd7,
                16'sd21,
                16'sd30,
                16'sd28,
                16'sd12,
                -16'sd13,
                -16'sd41,
                -16'sd57,
                -16'sd52,
                -16'sd22,
                16'sd25,
                16'sd75,
                16'sd103,
                16'sd93,
                16'sd39,
                -16'sd44,
                -16'sd127,
                -16'sd174,
                -16'sd155,
                -16'sd65,
                16'sd72,
                16'sd207,
                16'sd281,
                16'sd249,
                16'sd104,
                -16'sd114,
                -16'sd327,
                -16'sd444,
                -16'sd394,
                -16'sd165,
                16'sd182,
                16'sd526,
                16'sd720,
                16'sd648,
                16'sd277,
                -16'sd312,
                -16'sd929,
                -16'sd1321,
                -16'sd1250,
                -16'sd570,
                16'sd704,
                16'sd2387,
                16'sd4154,
                16'sd5622,
                16'sd6454    // Center pair
        };

endpackage

//--- hdl/fir_filter_top.sv
module fir_filter_top
        import fir_types_pkg::*, fir_coeff_pkg::*;
(
        input  logic    clk,
        input  logic    rst,
        input  sample_t sample_in,
        output acc_t    result
);

        pair_vec_t    pairs;
        product_vec_t products;

        tap_delay_line u_delay (
                .clk       (clk),
                .rst       (rst),
                .sample_in (sample_in),
                .pairs     (pairs)
        );

        fold_multiply u_fold_mul (
                .clk      (clk),
                .rst      (rst),
                .pairs    (pairs),
                .products (products)
        );

        adder_tree u_tree (
                .clk      (clk),
                .rst      (rst),
                .products (products),
                .result   (result)
        );

        // Whole pipeline drains to zero when fed zeros out of reset
        a_quiet_after_reset : assert property (
                @(posedge clk)
                rst ##1 (!rst && sample_in == '0) [*PIPE_LATENCY] |-> (result == '0)
        ) else $error("result nonzero after reset with zero input");

endmodule

//--- hdl/fir_types_pkg.sv
package fir_types_pkg;

        import fir_coeff_pkg::*;

        localparam int SAMPLE_W  = 16;
        localparam int FOLD_W    = SAMPLE_W + 1;              // Pair sum never overflows
        localparam int PRODUCT_W = FOLD_W + $bits(coeff_t);
        localparam int ACC_W     = 32;

        // Input sample
        typedef logic signed [SAMPLE_W-1:0] sample_t;

        // Tap k and its mirror 99-k
        typedef struct packed {
                sample_t near;
                sample_t far;
        } tap_pair_t;

        typedef tap_pair_t [HALF_TAPS-1:0] pair_vec_t;

        // Pre-adder output
        typedef logic signed [FOLD_W-1:0] fold_t;

        // Fold times coefficient
        typedef logic signed [PRODUCT_W-1:0] product_t;

        typedef product_t [HALF_TAPS-1:0] product_vec_t;

        // Filter output
        typedef logic signed [ACC_W-1:0] acc_t;

endpackage

//--- hdl/fold_multiply.sv
module fold_multiply
        import fir_types_pkg::*, fir_coeff_pkg::*;
(
        input  logic         clk,
        input  logic         rst,
        input  pair_vec_t    pairs,
        output product_vec_t products
);

        fold_t folds [HALF_TAPS];

        // Pre-add stage
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < HALF_TAPS; i++) begin
                                folds[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < HALF_TAPS; i++) begin
                                folds[i] <= pairs[i].near + pairs[i].far;   // Sign extended to 17 bits
                        end
                end
        end

        /*
         * Multiply stage. One multiplier per pair, so the folded
         * structure needs 50 multipliers instead of 100.
         */
        always_ff @(posedge clk) begin
                if (rst) begin
                        products <= '0;
                end else begin
                        for (int i = 0; i < HALF_TAPS; i++) begin
                                products[i] <= folds[i] * COEFFS[i];        // 33-bit signed
                        end
                end
        end

endmodule

//--- hdl/tap_delay_line.sv
module tap_delay_line
        import fir_types_pkg::*, fir_coeff_pkg::*;
(
        input  logic      clk,
        input  logic      rst,
        input  sample_t   sample_in,
        output pair_vec_t pairs
);

        sample_t taps [TAPS];     // taps[0] holds the newest sample

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int k = 0; k < TAPS; k++) begin
                                taps[k] <= '0;
                        end
                end else begin
                        taps[0] <= sample_in;
                        for (int k = 1; k < TAPS; k++) begin
                                taps[k] <= taps[k-1];    // Age by one sample
                        end
                end
        end

        // Fold the chain around its center
        always_ff @(posedge clk) begin
                if (rst) begin
                        pairs <= '0;
                end else begin
                        for (int i = 0; i < HALF_TAPS; i++) begin
                                pairs[i].near <= taps[i];
                                pairs[i].far  <= taps[TAPS-1-i];
                        end
                end
        end

        // Innermost far tap must come out of reset cleared
        a_reset_clears_chain : assert property (
                @(posedge clk) rst |=> (pairs[HALF_TAPS-1].far == '0)
        ) else $error("tap chain not cleared by reset");

endmodule

//--- sim.f
hdl/fir_coeff_pkg.sv
hdl/fir_types_pkg.sv
hdl/tap_delay_line.sv
hdl/fold_multiply.sv
hdl/adder_tree.sv
hdl/fir_filter_top.sv
verification/fir_tb.sv

//--- verification/fir_tb.sv
module fir_tb
        import fir_types_pkg::*, fir_coeff_pkg::*;
();

        logic    clk;
        logic    rst;
        sample_t sample_in;
        acc_t    result;

        sample_t     history [TAPS];   // history[0] is the newest consumed sample
        acc_t        pipe_q [$];        // Expected results still in flight
        acc_t        exp_result;
        logic [31:0] lfsr_state;
        int          errors;
        int          checks;
        int          tests_passed;
        int          tests_failed;

        fir_filter_top u_dut (
                .clk       (clk),
                .rst       (rst),
                .sample_in (sample_in),
                .result    (result)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // Full 100-tap response mirrored around the center pair
        function automatic int tap_coeff(input int k);
                return (k < HALF_TAPS) ? int'(COEFFS[k]) : int'(COEFFS[TAPS-1-k]);
        endfunction

        function automatic logic [31:0] lfsr_step(input logic [31:0] x);
                return x[0] ? ((x >> 1) ^ 32'h8020_0003) : (x >> 1);
        endfunction

        // One LFSR step per sample bit
        function automatic sample_t random_sample();
                sample_t s;
                s = '0;
                for (int b = 0; b < SAMPLE_W; b++) begin
                        s = {s[SAMPLE_W-2:0], lfsr_state[0]};
                        lfsr_state = lfsr_step(lfsr_state);
                end
                return s;
        endfunction

        // Reference model sees the same inputs as the DUT at each edge
        always @(posedge clk) begin : ref_model
                longint acc;
                if (rst) begin
                        for (int k = 0; k < TAPS; k++) begin
                                history[k] = '0;
                        end
                        pipe_q.delete();
                        for (int k = 0; k < PIPE_LATENCY; k++) begin
                                pipe_q.push_back('0);   // Cleared pipeline stages
                        end
                        exp_result = '0;
                end else begin
                        for (int k = TAPS - 1; k > 0; k--) begin
                                history[k] = history[k-1];
                        end
                        history[0] = sample_in;
                        acc = 0;
                        for (int k = 0; k < TAPS; k++) begin
                                acc += longint'(tap_coeff(k)) * longint'(history[k]);
                        end
                        pipe_q.push_back(acc_t'(acc));
                        exp_result = pipe_q.pop_front();   // Result due after this edge
                end
        end

        task automatic check_result(input acc_t expected, input acc_t actual);
                checks++;
                if (actual !== expected) begin
                        $display("** Error result: expected %h, actual %h at %0t",
                                 expected, actual, $time);
                        errors++;
                end
        endtask

        // Drive on the rising edge and sample at the falling edge
        task automatic tick(input sample_t s, input logic r);
                @(posedge clk);
                sample_in <= s;
                rst       <= r;
                @(negedge clk);
        endtask

        task automatic drain_pipeline(input int limit);
                int zero_run;
                int n;
                zero_run = 0;
                n = 0;
                while (zero_run < TAPS + PIPE_LATENCY && n < limit) begin
                        tick('0, 1'b0);
                        check_result(exp_result, result);
                        zero_run = (result == '0) ? zero_run + 1 : 0;
                        n++;
                end
                if (zero_run < TAPS + PIPE_LATENCY) begin
                        $display("Timeout: result did not settle to zero within %0d cycles",
                                 limit);
                        errors++;
                end
        endtask

        task automatic finish_test(input string name, input int err_before);
                if (errors == err_before) begin
                        tests_passed++;
                        $display("%s: passed", name);
                end else begin
                        tests_failed++;
                        $display("%s: failed with %0d mismatches", name, errors - err_before);
                end
        endtask

        task automatic test_reset_quiet();
                int err0;
                err0 = errors;
                for (int i = 0; i < 16; i++) begin
                        tick('0, 1'b1);
                        check_result('0, result);
                end
                for (int i = 0; i < 20; i++) begin
                        tick('0, 1'b0);
                        check_result('0, result);
                end
                finish_test("test_reset_quiet", err0);
        endtask

        task automatic test_impulse();
                int   err0;
                acc_t expected;
                err0 = errors;
                tick(sample_t'(1), 1'b0);
                for (int j = 1; j <= 120; j++) begin
                        tick('0, 1'b0);
                        expected = (j >= 10 && j < 110) ? acc_t'(tap_coeff(j - 10)) : '0;
                        check_result(expected, result);
                end
                drain_pipeline(400);
                finish_test("test_impulse", err0);
        endtask

        task automatic test_step();
                int     err0;
                longint coeff_sum;
                acc_t   expected;
                err0 = errors;
                coeff_sum = 0;
                for (int k = 0; k < TAPS; k++) begin
                        coeff_sum += tap_coeff(k);
                end
                expected = acc_t'(32767 * coeff_sum);
                for (int j = 0; j <= 120; j++) begin
                        tick(sample_t'(32767), 1'b0);
                        if (j >= 109) begin
                                check_result(expected, result);   // Window full of the step
                        end
                end
                drain_pipeline(400);
                finish_test("test_step", err0);
        endtask

        task automatic test_worst_case();
                int      err0;
                longint  peak;
                sample_t s;
                err0 = errors;
                peak = 0;
                for (int k = 0; k < TAPS; k++) begin
                        peak += (tap_coeff(k) < 0) ? -32768 * tap_coeff(k) : 32767 * tap_coeff(k);
                end
                for (int i = 0; i <= 120; i++) begin
                        if (i < TAPS) begin
                                // Sample i ends up in tap 99-i
                                s = (tap_coeff(TAPS - 1 - i) < 0) ? sample_t'(-32768) :
                                                                    sample_t'(32767);
                        end else begin
                                s = '0;
                        end
                        tick(s, 1'b0);
                        check_result(exp_result, result);
                        if (i == 109) begin
                                check_result(acc_t'(peak), result);
                        end
                end
                drain_pipeline(400);
                finish_test("test_worst_case", err0);
        endtask

        task automatic test_random_stream();
                int err0;
                err0 = errors;
                for (int i = 0; i < 300; i++) begin
                        tick(random_sample(), 1'b0);
                        check_result(exp_result, result);
                end
                drain_pipeline(400);
                finish_test("test_random_stream", err0);
        endtask

        task automatic test_midstream_reset();
                int err0;
                err0 = errors;
                for (int i = 0; i < 60; i++) begin
                        tick(random_sample(), 1'b0);
                        check_result(exp_result, result);
                end
                for (int i = 0; i < 3; i++) begin
                        tick(random_sample(), 1'b1);   // Pipeline full here
                        check_result(exp_result, result);
                end
                for (int i = 0; i < 150; i++) begin
                        tick(random_sample(), 1'b0);
                        check_result(exp_result, result);
                end
                drain_pipeline(400);
                finish_test("test_midstream_reset", err0);
        endtask

        initial begin
                rst          = 1'b1;
                sample_in    = '0;
                lfsr_state   = 32'hec06_4028;
                errors       = 0;
                checks       = 0;
                tests_passed = 0;
                tests_failed = 0;

                test_reset_quiet();
                test_impulse();
                test_step();
                test_worst_case();
                test_random_stream();
                test_midstream_reset();

                $display("Tests passed: %0d, failed: %0d, checks: %0d, mismatches: %0d",
                         tests_passed, tests_failed, checks, errors);
                if (tests_failed == 0 && errors == 0) begin
                        $display("STATUS: PASS");
                end else begin
                        $display("STATUS: FAIL");
                end
                $finish;
        end

endmodule
